// ==== src/uart_pkg.sv ====
package uart_pkg;

	localparam int FIFO_ADDR_WIDTH = 5;	// 32 entries per FIFO

	typedef logic [31:0]              bus_word_t;
	typedef logic [7:0]               uart_byte_t;
	typedef logic [23:0]              baud_div_t;	// clock cycles per serial bit
	typedef logic [FIFO_ADDR_WIDTH:0] fifo_count_t;

	localparam fifo_count_t FIFO_DEPTH = fifo_count_t'(1 << FIFO_ADDR_WIDTH);

	localparam bus_word_t UART_BASE_ADDR  = 32'h0000_0000;
	localparam bus_word_t FIFO_BUF_OFS    = 32'd0;
	localparam bus_word_t CTRL_OFS        = 32'd4;
	localparam bus_word_t CTRL_SET_OFS    = 32'd8;
	localparam bus_word_t CTRL_CLR_OFS    = 32'd12;
	localparam bus_word_t TX_STAT_OFS     = 32'd16;
	localparam bus_word_t TX_STAT_SET_OFS = 32'd20;
	localparam bus_word_t TX_STAT_CLR_OFS = 32'd24;
	localparam bus_word_t RX_STAT_OFS     = 32'd28;
	localparam bus_word_t RX_STAT_SET_OFS = 32'd32;
	localparam bus_word_t RX_STAT_CLR_OFS = 32'd36;

	localparam int CTRL_FLOW_BIT   = 27;
	localparam int CTRL_PARITY_BIT = 26;
	localparam int CTRL_STOP_BIT   = 25;
	localparam int CTRL_DATA_BIT   = 24;	// divider sits below this

	localparam int STAT_CLEAR_BIT = 31;
	localparam int STAT_IE_LSB    = 24;
	localparam int STAT_FLAG_LSB  = 16;
	localparam int STAT_WM_LSB    = 8;

	localparam baud_div_t   BAUD_DEFAULT         = 24'd69;
	localparam logic        FLOW_DEFAULT         = 1'b1;	// rts/cts on
	localparam logic        PARITY_DEFAULT       = 1'b1;	// even
	localparam logic        STOP_DEFAULT         = 1'b0;	// 1 stop bit
	localparam logic        DATA_DEFAULT         = 1'b1;	// 8 data bits
	localparam fifo_count_t TX_WATERMARK_DEFAULT = 6'd0;
	localparam fifo_count_t RX_WATERMARK_DEFAULT = 6'd1;
	localparam fifo_count_t RTS_MARGIN           = 6'd4;

	typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_t;
	typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_t;

endpackage

// ==== src/uart_fifo.sv ====
`timescale 1ns/10ps

module uart_fifo #(
	parameter int ADDR_WIDTH = uart_pkg::FIFO_ADDR_WIDTH
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 clear,
	input  logic                 push,
	input  uart_pkg::uart_byte_t wdata,
	input  logic                 pop,
	output uart_pkg::uart_byte_t rdata,
	output logic [ADDR_WIDTH:0]  size,
	output logic                 empty,
	output logic                 full
);
	import uart_pkg::*;

	uart_byte_t            mem [2**ADDR_WIDTH];
	logic [ADDR_WIDTH-1:0] wr_ptr;
	logic [ADDR_WIDTH-1:0] rd_ptr;
	logic                  do_push;
	logic                  do_pop;

	assign do_push = push && !full;	// ignored when full
	assign do_pop  = pop && !empty;
	assign empty   = size == '0;
	assign full    = size[ADDR_WIDTH];	// size reached the depth
	assign rdata   = mem[rd_ptr];	// head shows without a pop

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			size   <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: size <= size + 1'b1;
				2'b01: size <= size - 1'b1;
				default: size <= size;	// both or neither
			endcase
		end
	end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  clear,
	input  logic                  cts,
	input  logic                  flow_ctrl,
	input  logic                  parity,
	input  logic                  stop_bits,
	input  logic                  data_bits,
	input  uart_pkg::baud_div_t   baud_div,
	input  logic                  wena,
	input  uart_pkg::uart_byte_t  wdata,
	output logic                  tx,
	output uart_pkg::fifo_count_t size,
	output logic                  empty,
	output logic                  full
);
	import uart_pkg::*;

	tx_state_t  state;
	baud_div_t  bit_timer;
	uart_byte_t head;
	uart_byte_t shift;
	logic [2:0] bit_cnt;
	logic       par_bit;
	logic       stop_left;
	logic       start_frame;
	logic       bit_end;

	// cts only matters here, so a running frame always finishes
	assign start_frame = state == TX_IDLE && !empty && (!flow_ctrl || cts);
	assign bit_end     = bit_timer == '0;

	uart_fifo tx_fifo (
		.clk(clk),
		.reset(reset),
		.clear(clear),
		.push(wena),
		.wdata(wdata),
		.pop(start_frame),
		.rdata(head),
		.size(size),
		.empty(empty),
		.full(full)
	);

	always_ff @(posedge clk) begin
		if (start_frame) begin
			shift   <= head;
			par_bit <= data_bits ? ^head : ^head[6:0];	// even parity
		end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
			shift <= shift >> 1;
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state     <= TX_IDLE;
			tx        <= 1'b1;
			bit_timer <= '0;
			bit_cnt   <= '0;
			stop_left <= 1'b0;
		end else if (state == TX_IDLE) begin
			if (start_frame) begin
				state     <= TX_START;
				tx        <= 1'b0;
				bit_timer <= baud_div - 1'b1;
			end
		end else if (!bit_end) begin
			bit_timer <= bit_timer - 1'b1;
		end else begin
			bit_timer <= baud_div - 1'b1;
			case (state)
				TX_START: begin
					tx      <= shift[0];
					bit_cnt <= '0;
					state   <= TX_DATA;
				end
				TX_DATA: begin
					if (bit_cnt == {2'b11, data_bits}) begin	// last data bit done
						if (parity) begin
							tx    <= par_bit;
							state <= TX_PARITY;
						end else begin
							tx        <= 1'b1;
							stop_left <= stop_bits;
							state     <= TX_STOP;
						end
					end else begin
						tx      <= shift[0];
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				TX_PARITY: begin
					tx        <= 1'b1;
					stop_left <= stop_bits;
					state     <= TX_STOP;
				end
				TX_STOP: begin
					if (stop_left)
						stop_left <= 1'b0;	// second stop bit
					else
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

// ==== src/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  clear,
	input  logic                  rx,
	input  logic                  flow_ctrl,
	input  logic                  parity,
	input  logic                  stop_bits,
	input  logic                  data_bits,
	input  uart_pkg::baud_div_t   baud_div,
	input  logic                  rena,
	output logic                  rts,
	output uart_pkg::uart_byte_t  rdata,
	output uart_pkg::fifo_count_t size,
	output logic                  empty,
	output logic                  full,
	output logic                  noise_error,
	output logic                  parity_error,
	output logic                  frame_error,
	output logic                  overflow_error
);
	import uart_pkg::*;

	rx_state_t  state;
	baud_div_t  cnt;
	baud_div_t  half;
	logic       rx_meta;
	logic       rx_sync;
	logic       rx_prev;
	logic [1:0] smp;
	logic       sample_pt;
	logic       decide;
	logic       bit_val;
	logic       noisy;
	logic [2:0] bit_cnt;
	logic       stop_left;
	uart_byte_t shift;
	uart_byte_t rx_byte;
	logic       par_acc;
	logic       par_err;
	logic       frm_err;
	logic       noise_acc;
	logic       push_q;

	assign half      = baud_div >> 1;
	assign sample_pt = state != RX_IDLE && (cnt == half - 1'b1 || cnt == half);
	assign decide    = state != RX_IDLE && cnt == half + 1'b1;	// third sample
	assign bit_val   = (smp[1] & smp[0]) | (smp[1] & rx_sync) | (smp[0] & rx_sync);
	assign noisy     = !(smp[1] == smp[0] && smp[0] == rx_sync);
	assign rx_byte   = data_bits ? shift : {1'b0, shift[7:1]};	// 7 bits land high

	assign overflow_error = push_q && full;	// byte dropped by the FIFO
	assign rts            = !flow_ctrl || (FIFO_DEPTH - size >= RTS_MARGIN);

	uart_fifo rx_fifo (
		.clk(clk),
		.reset(reset),
		.clear(clear),
		.push(push_q),
		.wdata(rx_byte),
		.pop(rena),
		.rdata(rdata),
		.size(size),
		.empty(empty),
		.full(full)
	);

	always_ff @(posedge clk) begin
		if (sample_pt)
			smp <= {smp[0], rx_sync};
		if (decide) begin
			noise_acc <= (state == RX_START) ? noisy : noise_acc | noisy;
			case (state)
				RX_START: begin
					par_acc <= 1'b0;
					par_err <= 1'b0;
					frm_err <= 1'b0;
				end
				RX_DATA: begin
					shift   <= {bit_val, shift[7:1]};	// lsb first
					par_acc <= par_acc ^ bit_val;
				end
				RX_PARITY: par_err <= bit_val ^ par_acc;
				RX_STOP: frm_err <= frm_err | !bit_val;
				default: par_err <= par_err;
			endcase
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			rx_meta      <= 1'b1;
			rx_sync      <= 1'b1;
			rx_prev      <= 1'b1;
			state        <= RX_IDLE;
			cnt          <= '0;
			bit_cnt      <= '0;
			stop_left    <= 1'b0;
			push_q       <= 1'b0;
			noise_error  <= 1'b0;
			parity_error <= 1'b0;
			frame_error  <= 1'b0;
		end else begin
			rx_meta      <= rx;
			rx_sync      <= rx_meta;
			rx_prev      <= rx_sync;
			push_q       <= 1'b0;
			noise_error  <= 1'b0;
			parity_error <= 1'b0;
			frame_error  <= 1'b0;
			if (state == RX_IDLE) begin
				if (rx_prev && !rx_sync) begin	// falling edge starts a frame
					state <= RX_START;
					cnt   <= baud_div_t'(1);
				end
			end else begin
				cnt <= (cnt == baud_div - 1'b1) ? '0 : cnt + 1'b1;
				if (decide) begin
					case (state)
						RX_START: begin
							state   <= bit_val ? RX_IDLE : RX_DATA;	// glitch, not a start
							bit_cnt <= '0;
						end
						RX_DATA: begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == {2'b11, data_bits}) begin
								state     <= parity ? RX_PARITY : RX_STOP;
								stop_left <= stop_bits;
							end
						end
						RX_PARITY: state <= RX_STOP;
						RX_STOP: begin
							if (stop_left) begin
								stop_left <= 1'b0;
							end else begin
								state        <= RX_IDLE;	// mid stop bit
								push_q       <= 1'b1;
								noise_error  <= noise_acc | noisy;
								parity_error <= par_err;
								frame_error  <= frm_err | !bit_val;
							end
						end
						default: state <= RX_IDLE;
					endcase
				end
			end
		end
	end

endmodule

// ==== src/uart.sv ====
`timescale 1ns/10ps

module uart (
	input  logic               clk,
	input  logic               reset,
	input  logic               ena,
	input  logic               wen,
	input  uart_pkg::bus_word_t addr,
	input  uart_pkg::bus_word_t wdata,
	output uart_pkg::bus_word_t rdata,
	input  logic               rx,
	input  logic               cts,
	output logic               tx,
	output logic               rts,
	output logic               irq
);
	import uart_pkg::*;

	logic        ena_reg;
	logic        wen_reg;
	bus_word_t   addr_reg;
	bus_word_t   wr_ofs;
	bus_word_t   rd_ofs;
	logic        rd_active;
	logic        ctrl_we;
	logic        tx_we;
	logic        rx_we;
	logic [1:0]  wr_kind;	// 0 direct, 1 set, 2 clear
	bus_word_t   ctrl_reg;
	bus_word_t   tx_stat;
	bus_word_t   rx_stat;
	bus_word_t   ctrl_next;
	bus_word_t   tx_next;
	bus_word_t   rx_next;

	logic        flow_ctrl;
	logic        parity;
	logic        stop_bits;
	logic        data_bits;
	baud_div_t   baud_div;

	logic        tx_wena;
	logic        tx_clear;
	fifo_count_t tx_size;
	fifo_count_t tx_watermark;
	logic        tx_empty;
	logic        tx_full;
	logic        tx_wm_hit;
	logic        tx_ovf;
	logic [2:0]  tx_ie;	// overflow, watermark, empty

	logic        rx_rena;
	logic        rx_clear;
	uart_byte_t  rx_rdata;
	fifo_count_t rx_size;
	fifo_count_t rx_watermark;
	logic        rx_empty;
	logic        rx_full;
	logic        rx_wm_hit;
	logic [4:0]  rx_err;	// frame, parity, noise, underflow, overflow
	logic [6:0]  rx_ie;
	logic        noise_pulse;
	logic        parity_pulse;
	logic        frame_pulse;
	logic        overflow_pulse;

	function automatic bus_word_t alias_write(bus_word_t cur, bus_word_t val, logic [1:0] kind);
		case (kind)
			2'd1: return cur | val;
			2'd2: return cur & ~val;
			default: return val;
		endcase
	endfunction

	assign wr_ofs    = addr - UART_BASE_ADDR;
	assign rd_ofs    = addr_reg - UART_BASE_ADDR;
	assign rd_active = ena_reg && !wen_reg;
	assign tx_wena   = ena && wen && wr_ofs == FIFO_BUF_OFS;
	assign rx_rena   = rd_active && rd_ofs == FIFO_BUF_OFS;	// pop after the data is shown
	assign tx_wm_hit = tx_size <= tx_watermark;
	assign rx_wm_hit = rx_size >= rx_watermark;

	assign irq = |(tx_ie & {tx_ovf, tx_wm_hit, tx_empty}) || |(rx_ie & {rx_err, rx_wm_hit, rx_full});

	always_comb begin
		ctrl_reg = '0;
		ctrl_reg[CTRL_FLOW_BIT] = flow_ctrl;
		ctrl_reg[CTRL_PARITY_BIT] = parity;
		ctrl_reg[CTRL_STOP_BIT] = stop_bits;
		ctrl_reg[CTRL_DATA_BIT] = data_bits;
		ctrl_reg[$bits(baud_div_t)-1:0] = baud_div;
		tx_stat = '0;
		tx_stat[STAT_CLEAR_BIT] = tx_clear;
		tx_stat[STAT_IE_LSB +: 3] = tx_ie;
		tx_stat[STAT_FLAG_LSB +: 4] = {tx_ovf, tx_wm_hit, tx_empty, tx_full};
		tx_stat[STAT_WM_LSB +: $bits(fifo_count_t)] = tx_watermark;
		tx_stat[$bits(fifo_count_t)-1:0] = tx_size;
		rx_stat = '0;
		rx_stat[STAT_CLEAR_BIT] = rx_clear;
		rx_stat[STAT_IE_LSB +: 7] = rx_ie;
		rx_stat[STAT_FLAG_LSB +: 8] = {rx_err, rx_wm_hit, rx_empty, rx_full};
		rx_stat[STAT_WM_LSB +: $bits(fifo_count_t)] = rx_watermark;
		rx_stat[$bits(fifo_count_t)-1:0] = rx_size;
	end

	always_comb begin
		ctrl_we = 1'b0;
		tx_we   = 1'b0;
		rx_we   = 1'b0;
		wr_kind = 2'd0;
		if (ena && wen) begin
			case (wr_ofs)
				CTRL_OFS: ctrl_we = 1'b1;
				CTRL_SET_OFS: begin
					ctrl_we = 1'b1;
					wr_kind = 2'd1;
				end
				CTRL_CLR_OFS: begin
					ctrl_we = 1'b1;
					wr_kind = 2'd2;
				end
				TX_STAT_OFS: tx_we = 1'b1;
				TX_STAT_SET_OFS: begin
					tx_we   = 1'b1;
					wr_kind = 2'd1;
				end
				TX_STAT_CLR_OFS: begin
					tx_we   = 1'b1;
					wr_kind = 2'd2;
				end
				RX_STAT_OFS: rx_we = 1'b1;
				RX_STAT_SET_OFS: begin
					rx_we   = 1'b1;
					wr_kind = 2'd1;
				end
				RX_STAT_CLR_OFS: begin
					rx_we   = 1'b1;
					wr_kind = 2'd2;
				end
				default: wr_kind = 2'd0;
			endcase
		end
	end

	assign ctrl_next = alias_write(ctrl_reg, wdata, wr_kind);
	assign tx_next   = alias_write(tx_stat, wdata, wr_kind);
	assign rx_next   = alias_write(rx_stat, wdata, wr_kind);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			ena_reg      <= 1'b0;
			wen_reg      <= 1'b0;
			addr_reg     <= '0;
			flow_ctrl    <= FLOW_DEFAULT;
			parity       <= PARITY_DEFAULT;
			stop_bits    <= STOP_DEFAULT;
			data_bits    <= DATA_DEFAULT;
			baud_div     <= BAUD_DEFAULT;
			tx_watermark <= TX_WATERMARK_DEFAULT;
			rx_watermark <= RX_WATERMARK_DEFAULT;
			tx_ie        <= '0;
			rx_ie        <= '0;
			tx_ovf       <= 1'b0;
			rx_err       <= '0;
			tx_clear     <= 1'b0;
			rx_clear     <= 1'b0;
		end else begin
			ena_reg  <= ena;
			wen_reg  <= wen;
			addr_reg <= addr;
			tx_clear <= tx_we && tx_next[STAT_CLEAR_BIT];	// one cycle only
			rx_clear <= rx_we && rx_next[STAT_CLEAR_BIT];
			if (ctrl_we) begin
				flow_ctrl <= ctrl_next[CTRL_FLOW_BIT];
				parity    <= ctrl_next[CTRL_PARITY_BIT];
				stop_bits <= ctrl_next[CTRL_STOP_BIT];
				data_bits <= ctrl_next[CTRL_DATA_BIT];
				baud_div  <= ctrl_next[$bits(baud_div_t)-1:0];
			end
			if (tx_we) begin
				tx_ie        <= tx_next[STAT_IE_LSB +: 3];
				tx_ovf       <= tx_next[STAT_FLAG_LSB + 3];
				tx_watermark <= tx_next[STAT_WM_LSB +: $bits(fifo_count_t)];
			end else begin
				tx_ovf <= tx_ovf || (tx_wena && tx_full);
			end
			if (rx_we) begin
				rx_ie        <= rx_next[STAT_IE_LSB +: 7];
				rx_err       <= rx_next[STAT_FLAG_LSB + 3 +: 5];
				rx_watermark <= rx_next[STAT_WM_LSB +: $bits(fifo_count_t)];
			end else begin
				rx_err <= rx_err | {frame_pulse, parity_pulse, noise_pulse,
					rx_rena && rx_empty, overflow_pulse};
			end
		end
	end

	always_comb begin
		rdata = '0;
		if (rd_active) begin
			case (rd_ofs)
				FIFO_BUF_OFS: rdata = rx_empty ? '0 : bus_word_t'(rx_rdata);
				CTRL_OFS: rdata = ctrl_reg;
				TX_STAT_OFS: rdata = tx_stat;
				RX_STAT_OFS: rdata = rx_stat;
				default: rdata = '0;	// unmapped and alias addresses
			endcase
		end
	end

	uart_tx transmitter (
		.clk(clk),
		.reset(reset),
		.clear(tx_clear),
		.cts(cts),
		.flow_ctrl(flow_ctrl),
		.parity(parity),
		.stop_bits(stop_bits),
		.data_bits(data_bits),
		.baud_div(baud_div),
		.wena(tx_wena),
		.wdata(wdata[7:0]),
		.tx(tx),
		.size(tx_size),
		.empty(tx_empty),
		.full(tx_full)
	);

	uart_rx receiver (
		.clk(clk),
		.reset(reset),
		.clear(rx_clear),
		.rx(rx),
		.flow_ctrl(flow_ctrl),
		.parity(parity),
		.stop_bits(stop_bits),
		.data_bits(data_bits),
		.baud_div(baud_div),
		.rena(rx_rena),
		.rts(rts),
		.rdata(rx_rdata),
		.size(rx_size),
		.empty(rx_empty),
		.full(rx_full),
		.noise_error(noise_pulse),
		.parity_error(parity_pulse),
		.frame_error(frame_pulse),
		.overflow_error(overflow_pulse)
	);

endmodule

// ==== testbench/uart_asserts.sv ====
`timescale 1ns/10ps

module uart_asserts (
	input logic                clk,
	input logic                reset,
	input logic                tx,
	input logic                rts,
	input logic                irq,
	input logic [2:0]          tx_ie,
	input logic [6:0]          rx_ie,
	input uart_pkg::tx_state_t tx_state,
	input uart_pkg::baud_div_t bit_timer
);
	import uart_pkg::*;

	reset_lines: assert property (@(posedge clk) reset |-> tx && rts)
		else $error("tx or rts low during reset");

	quiet_irq: assert property (@(posedge clk) disable iff (reset)
		(tx_ie == '0 && rx_ie == '0) |-> !irq)
		else $error("irq high with all interrupt enables clear");

	idle_high: assert property (@(posedge clk) disable iff (reset)
		tx_state == TX_IDLE |-> tx)
		else $error("tx low while the transmitter is idle");

	// tx moves only at a bit boundary or when a frame starts
	bit_steady: assert property (@(posedge clk) disable iff (reset)
		$changed(tx) |-> $past(tx_state == TX_IDLE || bit_timer == '0))
		else $error("tx changed inside a bit period");

endmodule

bind uart uart_asserts checks (
	.clk(clk),
	.reset(reset),
	.tx(tx),
	.rts(rts),
	.irq(irq),
	.tx_ie(tx_ie),
	.rx_ie(rx_ie),
	.tx_state(transmitter.state),
	.bit_timer(transmitter.bit_timer)
);

// ==== testbench/uart_tb.sv ====
`timescale 1ns/10ps

module uart_tb;
	import uart_pkg::*;

	localparam int TX_WAIT_LIMIT = 4000;	// cycles to wait for one frame

	logic      clk;
	logic      reset;
	logic      ena;
	logic      wen;
	bus_word_t addr;
	bus_word_t wdata;
	bus_word_t rdata;
	logic      rx;
	logic      cts;
	logic      tx;
	logic      rts;
	logic      irq;

	bus_word_t  ctrl_model;	// frame format as last written
	uart_byte_t tx_bytes[$];
	logic       tx_frame_ok[$];
	int         test_errors;
	int         tests_passed;
	int         tests_failed;
	string      test_name;

	uart uut (
		.clk(clk),
		.reset(reset),
		.ena(ena),
		.wen(wen),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.rx(rx),
		.cts(cts),
		.tx(tx),
		.rts(rts),
		.irq(irq)
	);

	always #50 clk = ~clk;

	function automatic logic even_parity(uart_byte_t b);
		return ctrl_model[CTRL_DATA_BIT] ? ^b : ^b[6:0];
	endfunction

	task automatic track_ctrl(bus_word_t a, bus_word_t d);
		case (a - UART_BASE_ADDR)
			CTRL_OFS: ctrl_model = d;
			CTRL_SET_OFS: ctrl_model = ctrl_model | d;
			CTRL_CLR_OFS: ctrl_model = ctrl_model & ~d;
			default: ctrl_model = ctrl_model;
		endcase
	endtask

	task automatic bus_write(bus_word_t a, bus_word_t d);
		@(posedge clk);
		ena   <= 1'b1;
		wen   <= 1'b1;
		addr  <= a;
		wdata <= d;
		@(posedge clk);
		ena <= 1'b0;
		wen <= 1'b0;
		track_ctrl(a, d);
	endtask

	task automatic read_and_compare(bus_word_t a, bus_word_t exp);
		@(posedge clk);
		ena  <= 1'b1;
		wen  <= 1'b0;
		addr <= a;
		@(posedge clk);
		ena <= 1'b0;
		@(negedge clk);	// rdata settled from the registered address
		if (rdata !== exp) begin
			$display("MISMATCH at %0t: rdata (addr %h) expected %h, actual %h",
				$time, a, exp, rdata);
			test_errors++;
		end
	endtask

	task automatic drive_bit(logic v);
		rx <= v;
		repeat (int'(ctrl_model[$bits(baud_div_t)-1:0])) @(posedge clk);
	endtask

	// fault 1 flips the parity bit, fault 2 pulls the stop bit low
	task automatic send_frame(uart_byte_t b, logic [1:0] fault);
		int   nbits;
		logic par;
		nbits = ctrl_model[CTRL_DATA_BIT] ? 8 : 7;
		par   = even_parity(b) ^ (fault == 2'd1);
		@(posedge clk);
		drive_bit(1'b0);
		for (int i = 0; i < nbits; i++)
			drive_bit(b[i]);
		if (ctrl_model[CTRL_PARITY_BIT])
			drive_bit(par);
		drive_bit(fault != 2'd2);
		if (ctrl_model[CTRL_STOP_BIT])
			drive_bit(1'b1);
		drive_bit(1'b1);	// idle gap while the byte lands in the FIFO
	endtask

	task automatic decode_frame();
		int         baud;
		int         nbits;
		uart_byte_t b;
		logic       ok;
		baud  = int'(ctrl_model[$bits(baud_div_t)-1:0]);
		nbits = ctrl_model[CTRL_DATA_BIT] ? 8 : 7;
		b     = '0;
		ok    = 1'b1;
		repeat (baud / 2) @(negedge clk);	// centre of the start bit
		if (tx !== 1'b0)
			ok = 1'b0;
		for (int i = 0; i < nbits; i++) begin
			repeat (baud) @(negedge clk);
			b[i] = tx;
		end
		if (ctrl_model[CTRL_PARITY_BIT]) begin
			repeat (baud) @(negedge clk);
			if (tx !== ^b)
				ok = 1'b0;
		end
		repeat (baud) @(negedge clk);
		if (tx !== 1'b1)
			ok = 1'b0;
		if (ctrl_model[CTRL_STOP_BIT]) begin
			repeat (baud) @(negedge clk);
			if (tx !== 1'b1)
				ok = 1'b0;
		end
		tx_bytes.push_back(b);
		tx_frame_ok.push_back(ok);
	endtask

	// serial monitor on tx
	always @(negedge clk) begin
		if (!reset && tx === 1'b0)
			decode_frame();
	end

	task automatic expect_tx(uart_byte_t exp);
		int         waited;
		uart_byte_t got;
		logic       ok;
		waited = 0;
		while (tx_bytes.size() == 0 && waited < TX_WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (tx_bytes.size() == 0) begin
			$display("No frame appeared on tx within %0d cycles at %0t.", TX_WAIT_LIMIT, $time);
			test_errors++;
		end else begin
			got = tx_bytes.pop_front();
			ok  = tx_frame_ok.pop_front();
			if (got !== exp) begin
				$display("MISMATCH at %0t: tx byte expected %h, actual %h", $time, exp, got);
				test_errors++;
			end
			if (!ok) begin
				$display("The frame on tx at %0t had a bad start, parity or stop bit.", $time);
				test_errors++;
			end
		end
	endtask

	task automatic check_pin(string name, logic exp);
		logic act;
		@(negedge clk);
		act = (name == "irq") ? irq : rts;
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %b, actual %b", $time, name, exp, act);
			test_errors++;
		end
	endtask

	task automatic close_test();
		if (test_name != "" || test_errors != 0) begin
			if (test_errors == 0) begin
				$display("test %s: ok", test_name);
				tests_passed++;
			end else begin
				$display("test %s: %0d errors", test_name, test_errors);
				tests_failed++;
			end
		end
		test_errors = 0;
	endtask

	initial begin
		int         fd;
		int         nf;
		int         count;
		string      line;
		string      args;
		logic [7:0] cmd;
		bus_word_t  f1;
		bus_word_t  f2;
		bus_word_t  f3;
		clk   = 1'b0;
		reset = 1'b1;
		ena   = 1'b0;
		wen   = 1'b0;
		addr  = '0;
		wdata = '0;
		rx    = 1'b1;
		cts   = 1'b1;
		ctrl_model = '0;
		ctrl_model[CTRL_FLOW_BIT]   = FLOW_DEFAULT;
		ctrl_model[CTRL_PARITY_BIT] = PARITY_DEFAULT;
		ctrl_model[CTRL_STOP_BIT]   = STOP_DEFAULT;
		ctrl_model[CTRL_DATA_BIT]   = DATA_DEFAULT;
		ctrl_model[$bits(baud_div_t)-1:0] = BAUD_DEFAULT;
		test_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;
		test_name    = "";
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		fd = $fopen("testbench/uart_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/uart_testdata.txt.");
			tests_failed++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				nf   = $fgets(line, fd);
				while (line.len() > 0 && (line.getc(line.len() - 1) == 8'd10 ||
						line.getc(line.len() - 1) == 8'd13))
					line = line.substr(0, line.len() - 2);
				if (line.len() == 0 || line.getc(0) == "#")
					continue;
				cmd  = line.getc(0);
				args = line.substr(2, line.len() - 1);
				f1   = '0;
				f2   = '0;
				f3   = '0;
				nf    = $sscanf(args, "%h %h %h", f1, f2, f3);
				count = (nf >= 3) ? int'(f3) : 1;	// optional repeat count
				case (cmd)
					"N": begin
						close_test();
						test_name = args;
					end
					"W": begin
						for (int i = 0; i < count; i++)
							bus_write(f1, f2 + bus_word_t'(i));
					end
					"R": read_and_compare(f1, f2);
					"S": begin
						for (int i = 0; i < count; i++)
							send_frame(f1[7:0] + 8'(i), f2[1:0]);
					end
					"T": expect_tx(f1[7:0]);
					"C": begin
						@(posedge clk);
						cts <= f1[0];
					end
					"I": check_pin("irq", f1[0]);
					"F": check_pin("rts", f1[0]);
					default: begin
						$display("Unknown command in the test data: %s", line);
						test_errors++;
					end
				endcase
			end
			$fclose(fd);
		end

		close_test();
		$display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== testbench/uart_testdata.txt ====
# cmd field1 field2 [count], numbers in hex; count repeats with data or byte incremented
# W addr data, R addr expected, S byte fault (1 parity, 2 stop), T byte, C cts, I irq, F rts, N name
N registers
R 04 0D000045
W 04 0D000008
R 04 0D000008
R 10 00060000
R 1C 00020100
R 28 00000000
W 08 02000000
R 04 0F000008
W 0C 02000000
R 04 0D000008
W 14 00000300
R 10 00060300
W 18 00000100
R 10 00060200
W 18 00000200
R 10 00060000
W 20 00000400
R 1C 00020500
W 24 00000400
R 1C 00020100
N transmit
W 00 00000055
W 00 000000A3
W 00 0000003C
R 10 00000002
T 55
T A3
T 3C
R 10 00060000
W 04 0A000008
W 00 000000C5
T 45
W 04 0D000008
N receive
S 41 0
S 42 0
R 1C 00040102
R 00 00000041
R 00 00000042
R 1C 00020100
R 00 00000000
R 1C 00120100
W 24 00100000
R 1C 00020100
N errors
S 5A 1
I 0
R 1C 00440101
W 20 20000000
I 1
W 24 00400000
I 0
S 66 2
I 0
W 20 40000000
I 1
W 24 00800000
I 0
R 1C 60040102
W 1C 80000100
R 1C 00020100
I 0
N overflow
C 0
W 00 00000010 21
R 10 00090020
W 14 80000000
R 10 000E0000
W 18 00080000
R 10 00060000
N flow
W 00 00000031 2
R 10 00000002
R 10 00000002
C 1
T 31
T 32
R 10 00060000
F 1
S 40 0 1C
F 1
S 5C 0
F 0
S 5D 0 3
R 1C 00050120
S 60 0
R 1C 000D0120
R 00 00000040
R 00 00000041
F 0
W 20 80000000
R 1C 000A0100
F 1

// ==== filelist.f ====
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart.sv
testbench/uart_asserts.sv
testbench/uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module uart_tb -f filelist.f -Mdir obj_dir
./obj_dir/Vuart_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "^TB PASSED$" sim.log; then
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
